/* Makefile */
# Verilator build of the CPU testbench

SIM = obj_dir/cpu_sim
LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f src.f --top-module cpu_tb -o cpu_sim

run: compile
	./$(SIM) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* source/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Bits in an instruction or data word
`define WORD_SIZE 16

// 256 words of shared memory
`define MEM_ADDR_BITS 8

// Queue entries, and the credit count after reset
`define QUEUE_DEPTH 4

// Cycles from a data-port request to ready
`define DATA_LATENCY 3

`endif

/* source/cpu_pkg.sv */
`default_nettype none
`include "cpu_defs.svh"

package cpu_pkg;

	// Anything not listed decodes as a no-op
	typedef enum logic [3:0] {
		ADI = 4'h4,
		LWD = 4'h7,
		SWD = 4'h8,
		OUT = 4'hd,
		HLT = 4'he,
		ADD = 4'hf
	} opcode_e;

	typedef struct packed {
		opcode_e opcode;
		logic [1:0] rs;
		logic [1:0] rt;
		logic signed [7:0] imm;
	} i_fmt_t;

	typedef struct packed {
		opcode_e opcode;
		logic [1:0] rs;
		logic [1:0] rt;
		logic [1:0] rd;
		logic [5:0] pad;
	} r_fmt_t;

	typedef union packed {
		i_fmt_t i_fmt;
		r_fmt_t r_fmt;	// Register add only
	} instr_t;

	typedef struct packed {
		logic [`MEM_ADDR_BITS-1:0] addr;	// Where the word was fetched
		instr_t word;
	} queue_entry_t;

	typedef struct packed {
		logic valid;
		logic [`MEM_ADDR_BITS-1:0] addr;
		logic [`WORD_SIZE-1:0] data;
	} load_req_t;

endpackage

`default_nettype wire

/* source/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_top (
	input wire clk,
	input wire reset_n,
	input wire start,
	input wire cpu_pkg::load_req_t load,
	output logic out_valid,
	output logic [`WORD_SIZE-1:0] out_data,
	output logic halted
);
	import cpu_pkg::*;

	logic imem_read;
	logic [`MEM_ADDR_BITS-1:0] imem_addr;
	logic [`WORD_SIZE-1:0] imem_data;
	logic push_valid;
	queue_entry_t push_entry;
	logic credit_return;
	logic head_valid;
	queue_entry_t head_entry;
	logic pop;
	logic dmem_read;
	logic dmem_write;
	logic [`MEM_ADDR_BITS-1:0] dmem_addr;
	logic [`WORD_SIZE-1:0] dmem_wdata;
	logic [`WORD_SIZE-1:0] dmem_rdata;
	logic dmem_ready;

	dual_port_memory u_mem (
		.clk(clk), .reset_n(reset_n), .load(load),
		.imem_read(imem_read), .imem_addr(imem_addr), .imem_data(imem_data),
		.dmem_read(dmem_read), .dmem_write(dmem_write), .dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata), .dmem_ready(dmem_ready)
	);

	fetch_unit u_fetch (
		.clk(clk), .reset_n(reset_n), .start(start), .halted(halted),
		.credit_return(credit_return), .imem_data(imem_data),
		.imem_read(imem_read), .imem_addr(imem_addr),
		.push_valid(push_valid), .push_entry(push_entry)
	);

	instr_queue u_queue (
		.clk(clk), .reset_n(reset_n), .push_valid(push_valid), .push_entry(push_entry),
		.pop(pop), .head_valid(head_valid), .head_entry(head_entry),
		.credit_return(credit_return)
	);

	execute_unit u_exec (
		.clk(clk), .reset_n(reset_n), .start(start),
		.head_valid(head_valid), .head_entry(head_entry),
		.dmem_rdata(dmem_rdata), .dmem_ready(dmem_ready), .pop(pop),
		.dmem_read(dmem_read), .dmem_write(dmem_write), .dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata), .out_valid(out_valid), .out_data(out_data),
		.halted(halted)
	);

endmodule

`default_nettype wire

/* source/dual_port_memory.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module dual_port_memory (
	input wire clk,
	input wire reset_n,
	input wire cpu_pkg::load_req_t load,
	input wire imem_read,
	input wire [`MEM_ADDR_BITS-1:0] imem_addr,
	input wire dmem_read,
	input wire dmem_write,
	input wire [`MEM_ADDR_BITS-1:0] dmem_addr,
	input wire [`WORD_SIZE-1:0] dmem_wdata,
	output logic [`WORD_SIZE-1:0] imem_data,
	output logic [`WORD_SIZE-1:0] dmem_rdata,
	output logic dmem_ready
);
	localparam int CNT_W = $clog2(`DATA_LATENCY);
	localparam logic [CNT_W-1:0] LAST_WAIT = CNT_W'(`DATA_LATENCY - 1);

	logic [`WORD_SIZE-1:0] mem [2**`MEM_ADDR_BITS];
	logic [CNT_W-1:0] wait_cnt;
	logic access_done;
	logic write_done;

	// Last wait cycle of a data access, ready follows on the next edge
	assign access_done = (dmem_read || dmem_write) && !dmem_ready && wait_cnt == LAST_WAIT;
	assign write_done = access_done && dmem_write;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			wait_cnt <= '0;
			dmem_ready <= 1'b0;
		end else begin
			dmem_ready <= access_done;
			if (access_done || dmem_ready)
				wait_cnt <= '0;
			else if (dmem_read || dmem_write)
				wait_cnt <= wait_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (load.valid)
			mem[load.addr] <= load.data;	// Host load only while idle
		else if (write_done)
			mem[dmem_addr] <= dmem_wdata;

		// Forward a store that lands in this cycle
		if (imem_read)
			imem_data <= (write_done && dmem_addr == imem_addr) ? dmem_wdata : mem[imem_addr];

		if (access_done && dmem_read)
			dmem_rdata <= mem[dmem_addr];
	end

endmodule

`default_nettype wire

/* source/execute_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module execute_unit (
	input wire clk,
	input wire reset_n,
	input wire start,
	input wire head_valid,
	input wire cpu_pkg::queue_entry_t head_entry,
	input wire [`WORD_SIZE-1:0] dmem_rdata,
	input wire dmem_ready,
	output logic pop,
	output logic dmem_read,
	output logic dmem_write,
	output logic [`MEM_ADDR_BITS-1:0] dmem_addr,
	output logic [`WORD_SIZE-1:0] dmem_wdata,
	output logic out_valid,
	output logic [`WORD_SIZE-1:0] out_data,
	output logic halted
);
	import cpu_pkg::*;

	logic [`WORD_SIZE-1:0] regs [4];
	instr_t ins;
	logic [`WORD_SIZE-1:0] imm_ext;
	logic [`WORD_SIZE-1:0] ea;
	logic [1:0] load_rt;	// Destination of the pending load
	logic issue;

	assign ins = head_entry.word;
	assign imm_ext = `WORD_SIZE'(ins.i_fmt.imm);	// Sign extended
	assign ea = regs[ins.i_fmt.rs] + imm_ext;

	// Head stays put while a data access is outstanding
	assign pop = head_valid && !dmem_read && !dmem_write;
	// Popped while halted means discarded
	assign issue = pop && !halted;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			halted <= 1'b1;
			out_valid <= 1'b0;
			dmem_read <= 1'b0;
			dmem_write <= 1'b0;
		end else if (start) begin
			halted <= 1'b0;
			out_valid <= 1'b0;
			dmem_read <= 1'b0;
			dmem_write <= 1'b0;
		end else begin
			out_valid <= 1'b0;
			if (dmem_ready) begin
				dmem_read <= 1'b0;
				dmem_write <= 1'b0;
			end
			if (issue) begin
				case (ins.i_fmt.opcode)
					LWD: dmem_read <= 1'b1;
					SWD: dmem_write <= 1'b1;
					OUT: out_valid <= 1'b1;
					HLT: halted <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			for (int i = 0; i < 4; i++)
				regs[i] <= '0;
		end else if (dmem_ready && dmem_read) begin
			regs[load_rt] <= dmem_rdata;
		end else if (issue) begin
			case (ins.i_fmt.opcode)
				ADI: regs[ins.i_fmt.rt] <= ea;
				ADD: regs[ins.r_fmt.rd] <= regs[ins.r_fmt.rs] + regs[ins.r_fmt.rt];
				LWD, SWD: begin
					dmem_addr <= ea[`MEM_ADDR_BITS-1:0];	// Low bits of the sum
					dmem_wdata <= regs[ins.i_fmt.rt];
					load_rt <= ins.i_fmt.rt;
				end
				OUT: out_data <= regs[ins.i_fmt.rs];
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module fetch_unit (
	input wire clk,
	input wire reset_n,
	input wire start,
	input wire halted,
	input wire credit_return,
	input wire [`WORD_SIZE-1:0] imem_data,
	output logic imem_read,
	output logic [`MEM_ADDR_BITS-1:0] imem_addr,
	output logic push_valid,
	output cpu_pkg::queue_entry_t push_entry
);
	localparam int CRED_W = $clog2(`QUEUE_DEPTH + 1);
	localparam logic [CRED_W-1:0] FULL_CREDITS = CRED_W'(`QUEUE_DEPTH);

	logic [`MEM_ADDR_BITS-1:0] pc;
	logic [CRED_W-1:0] credits;
	logic [`MEM_ADDR_BITS-1:0] req_addr;	// Address of the word now returning

	// One read per cycle while a queue slot is guaranteed
	assign imem_read = !halted && credits != '0;
	assign imem_addr = pc;
	assign push_entry = {req_addr, imem_data};

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= '0;
			credits <= FULL_CREDITS;
			push_valid <= 1'b0;
		end else if (start) begin
			pc <= '0;
			credits <= FULL_CREDITS;
			push_valid <= 1'b0;
		end else begin
			push_valid <= imem_read;
			if (imem_read)
				pc <= pc + 1'b1;	// Wraps at the top of memory
			credits <= credits - CRED_W'(imem_read) + CRED_W'(credit_return);
		end
	end

	always_ff @(posedge clk) begin
		if (imem_read)
			req_addr <= pc;
	end

endmodule

`default_nettype wire

/* source/instr_queue.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module instr_queue (
	input wire clk,
	input wire reset_n,
	input wire push_valid,
	input wire cpu_pkg::queue_entry_t push_entry,
	input wire pop,
	output logic head_valid,
	output cpu_pkg::queue_entry_t head_entry,
	output logic credit_return
);
	import cpu_pkg::*;

	localparam int PTR_W = $clog2(`QUEUE_DEPTH);
	localparam int CNT_W = $clog2(`QUEUE_DEPTH + 1);

	queue_entry_t entries [`QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	assign head_valid = count != '0;
	assign head_entry = entries[rd_ptr];

	// Pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_return <= 1'b0;
		end else begin
			credit_return <= pop;	// One credit back per pop
			if (push_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + CNT_W'(push_valid) - CNT_W'(pop);
		end
	end

	// No overflow check, the fetch credits bound the pushes
	always_ff @(posedge clk) begin
		if (push_valid)
			entries[wr_ptr] <= push_entry;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+source
source/cpu_pkg.sv
source/dual_port_memory.sv
source/fetch_unit.sv
source/instr_queue.sv
source/execute_unit.sv
source/cpu_top.sv
testbench/cpu_chk.sv
testbench/cpu_scoreboard.sv
testbench/cpu_tb.sv

/* testbench/cpu_chk.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_chk (
	input wire clk,
	input wire reset_n,
	input wire start,
	input wire imem_read,
	input wire credit_return,
	input wire push_valid,
	input wire pop,
	input wire dmem_read,
	input wire dmem_write,
	input wire dmem_ready,
	input wire out_valid,
	input wire halted
);
	logic [7:0] credits_seen;	// Follows the fetch credit counter
	logic [7:0] occupancy;
	int violations;

	initial violations = 0;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			credits_seen <= 8'(`QUEUE_DEPTH);
			occupancy <= '0;
		end else begin
			if (start)
				credits_seen <= 8'(`QUEUE_DEPTH);
			else
				credits_seen <= credits_seen - 8'(imem_read) + 8'(credit_return);
			occupancy <= occupancy + 8'(push_valid) - 8'(pop);
		end
	end

	credit_bound: assert property (@(posedge clk) disable iff (!reset_n)
		credits_seen <= 8'(`QUEUE_DEPTH))
		else begin
			$error("credit count above queue depth");
			violations++;
		end

	no_overflow: assert property (@(posedge clk) disable iff (!reset_n)
		occupancy == 8'(`QUEUE_DEPTH) |-> !push_valid)
		else begin
			$error("push into a full queue");
			violations++;
		end

	ready_latency: assert property (@(posedge clk) disable iff (!reset_n)
		$rose(dmem_read || dmem_write) |-> ##(`DATA_LATENCY) dmem_ready)
		else begin
			$error("data port ready came at the wrong cycle");
			violations++;
		end

	quiet_halt: assert property (@(posedge clk) disable iff (!reset_n)
		halted |-> !out_valid)
		else begin
			$error("output while halted");
			violations++;
		end

endmodule

`default_nettype wire

/* testbench/cpu_scoreboard.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_scoreboard (
	input wire clk,
	input wire reset_n,
	input wire out_valid,
	input wire [`WORD_SIZE-1:0] out_data,
	input wire halted
);
	string test_name;
	logic [3:0][`WORD_SIZE-1:0] exp_vals;
	int exp_count;
	int seen;
	int errors;
	int pass_count;
	int fail_count;
	bit active;

	initial begin
		active = 0;
		seen = 0;
		errors = 0;
		exp_count = 0;
		pass_count = 0;
		fail_count = 0;
	end

	always @(posedge clk) begin
		if (reset_n && out_valid) begin
			if (!active) begin
				$display("Output 0x%h arrived between tests", out_data);
				fail_count++;
			end else if (halted) begin
				$display("Test %s emitted output 0x%h while halted", test_name, out_data);
				errors++;
			end else begin
				if (seen < exp_count && out_data !== exp_vals[seen]) begin
					$display("error %s: output %0d expected 0x%h actual 0x%h",
						test_name, seen, exp_vals[seen], out_data);
					errors++;
				end
				seen++;
			end
		end
	end

	task automatic expect_outputs(input string name, input int count,
			input logic [3:0][`WORD_SIZE-1:0] vals);
		test_name = name;
		exp_count = count;
		exp_vals = vals;
		seen = 0;
		errors = 0;
		active = 1;
	endtask

	task automatic close_test(input bit timed_out);
		active = 0;
		if (timed_out) begin
			$display("Test %s timed out waiting for halted", test_name);
			errors++;
		end
		if (seen != exp_count) begin
			$display("Test %s expected %0d outputs but got %0d", test_name, exp_count, seen);
			errors++;
		end
		if (errors == 0) begin
			$display("Test %s passed", test_name);
			pass_count++;
		end else begin
			$display("Test %s failed with %0d errors", test_name, errors);
			fail_count++;
		end
	endtask

endmodule

`default_nettype wire

/* testbench/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_tb;
	import cpu_pkg::*;

	localparam int NUM_TESTS = 6;
	localparam int PROG_LEN = 12;
	localparam int WAIT_LIMIT = 500;

	logic clk;
	logic reset_n;
	logic start;
	load_req_t load;
	logic out_valid;
	logic [`WORD_SIZE-1:0] out_data;
	logic halted;

	string names [NUM_TESTS];
	logic [`WORD_SIZE-1:0] progs [NUM_TESTS][PROG_LEN];
	int out_counts [NUM_TESTS];
	logic [3:0][`WORD_SIZE-1:0] exps [NUM_TESTS];
	logic [31:0] seed;
	logic [7:0] rnd_a;
	logic [7:0] rnd_b;
	bit late_idle;
	bit late_halt;

	cpu_top uut (
		.clk(clk), .reset_n(reset_n), .start(start), .load(load),
		.out_valid(out_valid), .out_data(out_data), .halted(halted)
	);

	cpu_scoreboard sb (
		.clk(clk), .reset_n(reset_n), .out_valid(out_valid),
		.out_data(out_data), .halted(halted)
	);

	bind cpu_top cpu_chk chk (
		.clk(clk), .reset_n(reset_n), .start(start), .imem_read(imem_read),
		.credit_return(credit_return), .push_valid(push_valid), .pop(pop),
		.dmem_read(dmem_read), .dmem_write(dmem_write), .dmem_ready(dmem_ready),
		.out_valid(out_valid), .halted(halted)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [15:0] enc_i(input logic [3:0] op, input logic [1:0] rs,
			input logic [1:0] rt, input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [15:0] enc_r(input logic [3:0] op, input logic [1:0] rs,
			input logic [1:0] rt, input logic [1:0] rd);
		return {op, rs, rt, rd, 6'b0};
	endfunction

	function automatic logic [15:0] sext(input logic [7:0] v);
		return {{8{v[7]}}, v};
	endfunction

	task automatic wait_halted(output bit timed_out);
		int cycles;
		cycles = 0;
		timed_out = 1;
		while (cycles < WAIT_LIMIT) begin
			@(posedge clk);
			if (halted) begin
				timed_out = 0;
				break;
			end
			cycles++;
		end
	endtask

	task automatic load_program(input int t);
		for (int i = 0; i < PROG_LEN; i++) begin
			@(posedge clk);
			load <= '{valid: 1'b1, addr: 8'(i), data: progs[t][i]};
		end
		@(posedge clk);
		load <= '0;
	endtask

	task automatic pulse_start();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic build_table();
		for (int t = 0; t < NUM_TESTS; t++) begin
			for (int i = 0; i < PROG_LEN; i++)
				progs[t][i] = '0;	// Opcode 0 is a no-op
			exps[t] = '0;
		end

		names[0] = "adi_out";
		progs[0][0] = enc_i(ADI, 0, 1, 8'h05);
		progs[0][1] = enc_i(ADI, 0, 2, 8'hfd);	// Negative immediate
		progs[0][2] = enc_i(OUT, 1, 0, 0);
		progs[0][3] = enc_i(OUT, 2, 0, 0);
		progs[0][4] = enc_i(HLT, 0, 0, 0);
		out_counts[0] = 2;
		exps[0][0] = sext(8'h05);
		exps[0][1] = sext(8'hfd);

		names[1] = "reg_add";
		progs[1][0] = enc_i(ADI, 0, 1, 8'h12);
		progs[1][1] = enc_i(ADI, 0, 2, 8'h34);
		progs[1][2] = enc_r(ADD, 1, 2, 3);
		progs[1][3] = enc_i(OUT, 3, 0, 0);
		progs[1][4] = enc_i(HLT, 0, 0, 0);
		out_counts[1] = 1;
		exps[1][0] = sext(8'h12) + sext(8'h34);

		// 0xfe plus 0x10 wraps to address 0x0e
		names[2] = "store_load_wrap";
		progs[2][0] = enc_i(ADI, 0, 1, 8'h7f);
		progs[2][1] = enc_i(ADI, 1, 1, 8'h7f);
		progs[2][2] = enc_i(ADI, 0, 2, 8'h55);
		progs[2][3] = enc_i(SWD, 1, 2, 8'h10);
		progs[2][4] = enc_i(LWD, 0, 3, 8'h0e);
		progs[2][5] = enc_i(OUT, 3, 0, 0);
		progs[2][6] = enc_i(HLT, 0, 0, 0);
		out_counts[2] = 1;
		exps[2][0] = sext(8'h55);

		seed = 32'h982e_1bb7;
		seed = lcg_next(seed);
		rnd_a = seed[23:16];
		seed = lcg_next(seed);
		rnd_b = seed[23:16];
		names[3] = "back_pressure";
		progs[3][0] = enc_i(ADI, 0, 1, rnd_a);
		progs[3][1] = enc_i(SWD, 0, 1, 8'h60);
		progs[3][2] = enc_i(ADI, 0, 2, rnd_b);
		progs[3][3] = enc_i(SWD, 0, 2, 8'h61);
		progs[3][4] = enc_i(LWD, 0, 3, 8'h60);
		progs[3][5] = enc_i(OUT, 3, 0, 0);
		progs[3][6] = enc_i(LWD, 0, 3, 8'h61);
		progs[3][7] = enc_i(OUT, 3, 0, 0);
		progs[3][8] = enc_i(LWD, 0, 0, 8'h60);
		progs[3][9] = enc_i(OUT, 0, 0, 0);
		progs[3][10] = enc_i(HLT, 0, 0, 0);
		out_counts[3] = 3;
		exps[3][0] = sext(rnd_a);
		exps[3][1] = sext(rnd_b);
		exps[3][2] = sext(rnd_a);

		// Store at 2 replaces the OUT at 9 with one that emits r1
		names[4] = "self_modify";
		progs[4][0] = enc_i(ADI, 0, 1, 8'h33);
		progs[4][1] = enc_i(LWD, 0, 2, 8'd11);
		progs[4][2] = enc_i(SWD, 0, 2, 8'd9);
		progs[4][9] = enc_i(OUT, 0, 0, 0);
		progs[4][10] = enc_i(HLT, 0, 0, 0);
		progs[4][11] = enc_i(OUT, 1, 0, 0);	// Data word for the store
		out_counts[4] = 1;
		exps[4][0] = sext(8'h33);

		names[5] = "halt_restart";
		progs[5][0] = enc_i(OUT, 1, 0, 0);	// r1 cleared by start
		progs[5][1] = enc_i(ADI, 0, 2, 8'h07);
		progs[5][2] = enc_i(OUT, 2, 0, 0);
		progs[5][3] = enc_i(HLT, 0, 0, 0);
		progs[5][4] = enc_i(OUT, 2, 0, 0);
		progs[5][5] = enc_i(OUT, 2, 0, 0);
		out_counts[5] = 2;
		exps[5][0] = 16'h0000;
		exps[5][1] = sext(8'h07);
	endtask

	initial begin
		reset_n = 1'b0;
		start = 1'b0;
		load = '0;
		build_table();
		repeat (8) @(posedge clk);
		reset_n <= 1'b1;

		for (int t = 0; t < NUM_TESTS; t++) begin
			sb.expect_outputs(names[t], out_counts[t], exps[t]);
			wait_halted(late_idle);
			if (late_idle)
				$display("Processor never went idle before test %s", names[t]);
			load_program(t);
			pulse_start();
			wait_halted(late_halt);
			sb.close_test(late_idle || late_halt);
		end

		if (uut.chk.violations != 0)
			$display("Assertion checker flagged %0d violations", uut.chk.violations);
		$display("Summary: %0d passed, %0d failed", sb.pass_count, sb.fail_count);
		if (sb.fail_count == 0 && sb.pass_count == NUM_TESTS && uut.chk.violations == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire
